// File: verilog/dbg_pkg.sv
// ######################################################################
// shared widths, serial timing, command codes and state encodings
// for the debug port; modules pull it in with a wildcard import
// ######################################################################
package dbg_pkg;

    // serial payload and probe
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] probe_word_t;

    localparam int PROBE_BYTES   = 4;
    // kept small so simulation runs fast
    localparam int TICKS_PER_BIT = 8;
    localparam int DUMP_PERIOD   = 2000;

    localparam byte_t CMD_DUMP   = 8'h44;
    localparam byte_t CMD_PAUSE  = 8'h50;
    localparam byte_t CMD_RESUME = 8'h52;
    localparam byte_t NEWLINE    = 8'h0A;

    // counter widths derived from the timing above
    typedef logic [$clog2(TICKS_PER_BIT)-1:0] tick_t;
    typedef logic [2:0]                       bit_idx_t;
    typedef logic [$clog2(DUMP_PERIOD)-1:0]   period_cnt_t;
    typedef logic [$clog2(PROBE_BYTES):0]     byte_cnt_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {SEQ_IDLE, SEQ_LOAD, SEQ_SEND, SEQ_WAIT} seq_state_e;

    // one-cycle command pulses from the decoder
    typedef struct packed {
        logic dump;
        logic pause;
        logic resume;
    } cmd_t;

endpackage

// File: verilog/uart_rx.sv
// ######################################################################
// 8N1 serial receiver, samples each bit in the middle of its period
// ######################################################################
`timescale 1ns/1ps

module uart_rx
    import dbg_pkg::*;
(
    input  logic  clk_in,
    input  logic  reset,
    input  logic  i_rx,
    output byte_t o_data,
    output logic  o_valid
);

    logic      rx_meta;
    logic      rx_sync;
    rx_state_e state;
    tick_t     tick;
    bit_idx_t  bit_idx;
    byte_t     shreg;

    // two flops against metastability, idle line is high
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state   <= RX_IDLE;
            tick    <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            tick    <= tick + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // half a bit in: confirm the start bit is still low
                    if (tick == tick_t'(TICKS_PER_BIT / 2 - 1)) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (tick == tick_t'(TICKS_PER_BIT - 1)) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick == tick_t'(TICKS_PER_BIT - 1)) begin
                        // a low stop bit drops the byte silently
                        o_valid <= rx_sync;
                        state   <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data path, LSB arrives first
    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && tick == tick_t'(TICKS_PER_BIT - 1)) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        if (state == RX_STOP && tick == tick_t'(TICKS_PER_BIT - 1)) begin
            o_data <= shreg;
        end
    end

endmodule

// File: verilog/uart_tx.sv
// ######################################################################
// 8N1 serial transmitter, sends one byte per i_start pulse
// ######################################################################
`timescale 1ns/1ps

module uart_tx
    import dbg_pkg::*;
(
    input  logic  clk_in,
    input  logic  reset,
    input  logic  i_start,
    input  byte_t i_data,
    output logic  o_busy,
    output logic  o_dout
);

    tx_state_e state;
    tick_t     tick;
    bit_idx_t  bit_idx;
    byte_t     shreg;

    assign o_busy = (state != TX_IDLE);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state   <= TX_IDLE;
            tick    <= '0;
            bit_idx <= '0;
            o_dout  <= 1'b1;
        end else begin
            tick <= tick + 1'b1;
            case (state)
                TX_IDLE: begin
                    tick <= '0;
                    if (i_start) begin
                        o_dout <= 1'b0;
                        state  <= TX_START;
                    end
                end
                TX_START: begin
                    if (tick == tick_t'(TICKS_PER_BIT - 1)) begin
                        bit_idx <= '0;
                        o_dout  <= shreg[0];
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (tick == tick_t'(TICKS_PER_BIT - 1)) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            o_dout <= 1'b1;
                            state  <= TX_STOP;
                        end else begin
                            o_dout <= shreg[1];
                        end
                    end
                end
                TX_STOP: begin
                    // line already high, busy drops at the end of the stop bit
                    if (tick == tick_t'(TICKS_PER_BIT - 1)) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == TX_IDLE && i_start) begin
            shreg <= i_data;
        end else if (state == TX_DATA && tick == tick_t'(TICKS_PER_BIT - 1)) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

// File: verilog/dbg_cmd_decode.sv
// ######################################################################
// turns received command bytes into dump, pause and resume pulses
// ######################################################################
`timescale 1ns/1ps

module dbg_cmd_decode
    import dbg_pkg::*;
(
    input  logic  clk_in,
    input  logic  reset,
    input  byte_t i_byte,
    input  logic  i_valid,
    output cmd_t  o_cmd
);

    cmd_t cmd_next;

    // unknown bytes fall through with no pulse
    always_comb begin
        cmd_next = '0;
        if (i_valid) begin
            case (i_byte)
                CMD_DUMP:   cmd_next.dump   = 1'b1;
                CMD_PAUSE:  cmd_next.pause  = 1'b1;
                CMD_RESUME: cmd_next.resume = 1'b1;
                default:    cmd_next = '0;
            endcase
        end
    end

    // pulses come out one cycle after i_valid
    always_ff @(posedge clk_in) begin
        if (reset) begin
            o_cmd <= '0;
        end else begin
            o_cmd <= cmd_next;
        end
    end

endmodule

// File: verilog/dbg_dump_seq.sv
// ######################################################################
// dump sequencer: period counter, enable flag and frame FSM
// snapshots the probe and feeds it byte by byte to the transmitter
// ######################################################################
`timescale 1ns/1ps

module dbg_dump_seq
    import dbg_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  cmd_t        i_cmd,
    input  probe_word_t i_probe,
    input  logic        i_tx_busy,
    output logic        o_tx_start,
    output byte_t       o_tx_data,
    output logic        o_dump_active
);

    seq_state_e  state;
    period_cnt_t period_cnt;
    logic        enable;
    logic        wrap;
    logic        trigger;
    logic        close;
    byte_cnt_t   byte_cnt;
    probe_word_t snap;
    byte_t       next_byte;

    assign wrap    = (period_cnt == period_cnt_t'(DUMP_PERIOD - 1));
    assign trigger = i_cmd.dump || (wrap && enable);

    // active from the snapshot until the newline has gone out
    assign o_dump_active = (state != SEQ_IDLE);

    // top byte first, newline once the data bytes are used up
    always_comb begin
        next_byte = NEWLINE;
        if (!close) begin
            next_byte = snap[8 * (byte_cnt - 1'b1) +: 8];
        end
    end

    // period counter runs regardless of enable
    always_ff @(posedge clk_in) begin
        if (reset) begin
            period_cnt <= '0;
            enable     <= 1'b1;
        end else begin
            period_cnt <= wrap ? '0 : period_cnt + 1'b1;
            if (i_cmd.pause) begin
                enable <= 1'b0;
            end else if (i_cmd.resume) begin
                enable <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state      <= SEQ_IDLE;
            close      <= 1'b0;
            byte_cnt   <= '0;
            o_tx_start <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    // triggers outside idle are simply lost
                    if (trigger) begin
                        byte_cnt <= byte_cnt_t'(PROBE_BYTES);
                        close    <= 1'b0;
                        state    <= SEQ_LOAD;
                    end
                end
                SEQ_LOAD: begin
                    if (byte_cnt == '0) begin
                        close <= 1'b1;
                    end
                    state <= SEQ_SEND;
                end
                SEQ_SEND: begin
                    if (!i_tx_busy) begin
                        o_tx_start <= 1'b1;
                        state      <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    // busy only rises after the start pulse, so skip that cycle
                    if (o_tx_start) begin
                        o_tx_start <= 1'b0;
                    end else if (!i_tx_busy) begin
                        if (close) begin
                            close <= 1'b0;
                            state <= SEQ_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                            state    <= SEQ_LOAD;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // snapshot and outgoing byte
    always_ff @(posedge clk_in) begin
        if (state == SEQ_IDLE && trigger) begin
            snap <= i_probe;
        end
        if (state == SEQ_SEND && !i_tx_busy) begin
            o_tx_data <= next_byte;
        end
    end

endmodule

// File: verilog/dbg_port_top.sv
// ######################################################################
// debug port top: serial commands in, probe snapshot frames out
// ######################################################################
`timescale 1ns/1ps

module dbg_port_top
    import dbg_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic        i_rx,
    input  probe_word_t i_probe,
    output logic        o_tx,
    output byte_t       o_cmd_byte,
    output logic        o_cmd_valid,
    output logic        o_dump_active
);

    byte_t rx_byte;
    logic  rx_valid;
    cmd_t  cmd;
    logic  tx_start;
    byte_t tx_data;
    logic  tx_busy;

    // every received byte is also shown at the top
    assign o_cmd_byte  = rx_byte;
    assign o_cmd_valid = rx_valid;

    uart_rx i_uart_rx (
        .clk_in (clk_in),
        .reset  (reset),
        .i_rx   (i_rx),
        .o_data (rx_byte),
        .o_valid(rx_valid)
    );

    dbg_cmd_decode i_dbg_cmd_decode (
        .clk_in (clk_in),
        .reset  (reset),
        .i_byte (rx_byte),
        .i_valid(rx_valid),
        .o_cmd  (cmd)
    );

    dbg_dump_seq i_dbg_dump_seq (
        .clk_in       (clk_in),
        .reset        (reset),
        .i_cmd        (cmd),
        .i_probe      (i_probe),
        .i_tx_busy    (tx_busy),
        .o_tx_start   (tx_start),
        .o_tx_data    (tx_data),
        .o_dump_active(o_dump_active)
    );

    uart_tx i_uart_tx (
        .clk_in (clk_in),
        .reset  (reset),
        .i_start(tx_start),
        .i_data (tx_data),
        .o_busy (tx_busy),
        .o_dout (o_tx)
    );

endmodule

// File: bench/tb_clock.sv
// ######################################################################
// clock and reset source for the debug port testbench
// ######################################################################
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk,
    output logic o_reset
);

    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // held for 16 cycles, released on a falling edge
    initial begin
        o_reset = 1'b1;
        repeat (16) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

// File: bench/dbg_port_checker.sv
// ######################################################################
// watches the debug port outputs, rebuilds frames from the serial line
// and compares them with the expected bytes, one summary line per test
// ######################################################################
`timescale 1ns/1ps

module dbg_port_checker
    import dbg_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic        i_tx,
    input  probe_word_t i_probe,
    input  byte_t       i_cmd_byte,
    input  logic        i_cmd_valid,
    input  logic        i_dump_active,
    output int          o_errors
);

    probe_word_t probe_q;
    probe_word_t frame_probe;
    byte_t       last_sent;
    string       test_name;
    int          test_num = 0;
    int          test_errors = 0;
    int          frames = 0;
    int          byte_pos = 0;
    int          cmds_sent = 0;
    int          cmds_seen = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    initial o_errors = 0;

    // byte k of a frame: probe bytes from the top down, then a newline
    function automatic byte_t expected_byte(input probe_word_t probe, input int k);
        if (k < 4) begin
            return probe[31 - 8 * k -: 8];
        end
        return 8'h0A;
    endfunction

    task automatic log_error();
        test_errors++;
        o_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("test %0d %s: %s", test_num, test_name, msg);
        log_error();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            log_error();
        end
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name   = name;
        test_errors = 0;
        frames      = 0;
        cmds_sent   = 0;
        cmds_seen   = 0;
    endtask

    task automatic note_cmd(input byte_t b);
        last_sent = b;
        cmds_sent++;
    endtask

    // outputs must sit at their reset values while nothing happens
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_in);
            check_value("o_tx", i_tx, 1'b1);
            check_value("o_dump_active", i_dump_active, 1'b0);
            check_value("o_cmd_valid", i_cmd_valid, 1'b0);
        end
    endtask

    task automatic finish_test(input int min_frames, input int max_frames);
        if (frames < min_frames || frames > max_frames) begin
            report_failure($sformatf("expected %0d to %0d frames on o_tx but %0d arrived",
                                     min_frames, max_frames, frames));
        end
        if (byte_pos != 0) begin
            report_failure("a frame on o_tx was cut off");
        end
        if (cmds_seen != cmds_sent) begin
            report_failure($sformatf("%0d command bytes sent but o_cmd_valid pulsed %0d times",
                                     cmds_sent, cmds_seen));
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok, %0d frames", test_num, test_name, frames);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", test_num, test_name, test_errors);
        end
    endtask

    task automatic report_counts();
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, o_errors);
    endtask

    // probe is driven on falling edges, so take it from the rising edge
    always @(posedge clk_in) begin
        probe_q <= i_probe;
    end

    always @(negedge clk_in) begin
        if (!reset && i_cmd_valid === 1'b1) begin
            cmds_seen++;
            check_value("o_cmd_byte", i_cmd_byte, last_sent);
        end
    end

    // serial decoder on o_tx, sampling in the middle of each bit
    initial begin : line_decoder
        byte_t rx_b;
        forever begin
            @(negedge clk_in);
            if (!reset && i_tx === 1'b0) begin
                if (byte_pos == 0) begin
                    frame_probe = probe_q;
                end
                repeat (TICKS_PER_BIT / 2) @(negedge clk_in);
                if (i_tx !== 1'b0) begin
                    report_failure("start bit on o_tx did not last half a bit");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (TICKS_PER_BIT) @(negedge clk_in);
                    rx_b[i] = i_tx;
                end
                repeat (TICKS_PER_BIT) @(negedge clk_in);
                if (i_tx !== 1'b1) begin
                    report_failure("stop bit on o_tx was low");
                end
                check_value($sformatf("o_tx byte %0d", byte_pos), rx_b,
                            expected_byte(frame_probe, byte_pos));
                byte_pos = (byte_pos + 1) % 5;
                if (byte_pos == 0) begin
                    frames++;
                end
            end
        end
    end

endmodule

// File: bench/dbg_port_properties.sv
// ######################################################################
// concurrent checks on the byte handoff into the transmitter,
// bound into every uart_tx instance
// ######################################################################
`timescale 1ns/1ps

module dbg_port_properties
    import dbg_pkg::*;
(
    input logic  clk_in,
    input logic  reset,
    input logic  i_start,
    input logic  i_busy,
    input byte_t i_data,
    input logic  i_dout
);

    // number of failed assertions
    int fail_count = 0;

    // a new byte is only started on an idle transmitter
    start_when_idle: assert property (@(posedge clk_in) disable iff (reset)
        !(i_start && i_busy)) else begin
        $error("tx_start raised while tx_busy is high");
        fail_count++;
    end

    line_idle_high: assert property (@(posedge clk_in) disable iff (reset)
        !i_busy |-> i_dout) else begin
        $error("o_dout low while the transmitter is idle");
        fail_count++;
    end

    // the sequencer must not touch the byte in flight
    data_held: assert property (@(posedge clk_in) disable iff (reset)
        i_busy |=> $stable(i_data)) else begin
        $error("tx_data changed while tx_busy is high");
        fail_count++;
    end

endmodule

bind uart_tx dbg_port_properties i_dbg_port_properties (
    .clk_in (clk_in),
    .reset  (reset),
    .i_start(i_start),
    .i_busy (o_busy),
    .i_data (i_data),
    .i_dout (o_dout)
);

// File: bench/dbg_port_tb.sv
// ######################################################################
// debug port testbench: sends serial commands, holds the probe and
// runs pause, dump and periodic tests against the checker
// ######################################################################
`timescale 1ns/1ps

module dbg_port_tb
    import dbg_pkg::*;
;

    localparam int BYTE_CYCLES    = 12 * TICKS_PER_BIT;
    localparam int FRAME_CYCLES   = 5 * (10 * TICKS_PER_BIT + 8);
    localparam int RESUME_PERIODS = 5;
    // sum of the test windows, doubled as margin
    localparam int TEST_CYCLES = 16 + DUMP_PERIOD / 2 + 4 * BYTE_CYCLES + 3 * DUMP_PERIOD
        + 2 * (BYTE_CYCLES + FRAME_CYCLES) + 2 * BYTE_CYCLES + 3 * FRAME_CYCLES
        + BYTE_CYCLES + RESUME_PERIODS * DUMP_PERIOD + FRAME_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic        clk_in;
    logic        reset;
    logic        rx_line;
    probe_word_t probe;
    logic        o_tx;
    byte_t       o_cmd_byte;
    logic        o_cmd_valid;
    logic        o_dump_active;
    int          errors;
    int          cycle_count;
    integer      seed = 32'h2fc2_bc69;
    byte_t       unknown_bytes [3] = '{8'h00, 8'hA5, 8'h64};

    tb_clock i_tb_clock (.o_clk(clk_in), .o_reset(reset));

    dbg_port_top i_dbg_port_top (
        .clk_in       (clk_in),
        .reset        (reset),
        .i_rx         (rx_line),
        .i_probe      (probe),
        .o_tx         (o_tx),
        .o_cmd_byte   (o_cmd_byte),
        .o_cmd_valid  (o_cmd_valid),
        .o_dump_active(o_dump_active)
    );

    dbg_port_checker i_dbg_port_checker (
        .clk_in       (clk_in),
        .reset        (reset),
        .i_tx         (o_tx),
        .i_probe      (probe),
        .i_cmd_byte   (o_cmd_byte),
        .i_cmd_valid  (o_cmd_valid),
        .i_dump_active(o_dump_active),
        .o_errors     (errors)
    );

    // start bit, data LSB first, stop bit, one idle bit
    task automatic send_byte(input byte_t b);
        logic [10:0] line_bits;
        line_bits = {2'b11, b, 1'b0};
        i_dbg_port_checker.note_cmd(b);
        for (int i = 0; i < 11; i++) begin
            @(negedge clk_in);
            rx_line = line_bits[i];
            repeat (TICKS_PER_BIT - 1) @(negedge clk_in);
        end
    endtask

    task automatic wait_dump(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (o_dump_active !== level && n < limit) begin
            @(negedge clk_in);
            n++;
        end
        if (o_dump_active !== level) begin
            i_dbg_port_checker.report_failure($sformatf("%s not seen within %0d cycles",
                                                        what, limit));
        end
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing the tests", cycle_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : test_sequence
        rx_line = 1'b1;
        probe   = '0;
        wait (reset === 1'b0);
        @(negedge clk_in);
        probe = $random(seed);

        i_dbg_port_checker.start_test("reset_idle");
        i_dbg_port_checker.check_idle(DUMP_PERIOD / 2);
        i_dbg_port_checker.finish_test(0, 0);

        // paused, unknown bytes must not restart anything
        i_dbg_port_checker.start_test("pause_quiet");
        send_byte(CMD_PAUSE);
        for (int i = 0; i < 3; i++) begin
            send_byte(unknown_bytes[i]);
            repeat (DUMP_PERIOD) @(negedge clk_in);
        end
        i_dbg_port_checker.finish_test(0, 0);

        i_dbg_port_checker.start_test("dump_on_command");
        probe = $random(seed);
        repeat (2) begin
            send_byte(CMD_DUMP);
            wait_dump(1'b1, BYTE_CYCLES, "frame start");
            wait_dump(1'b0, FRAME_CYCLES, "frame end");
        end
        i_dbg_port_checker.finish_test(2, 2);

        // second dump lands while the first frame is still going out
        i_dbg_port_checker.start_test("dump_while_active");
        probe = $random(seed);
        send_byte(CMD_DUMP);
        wait_dump(1'b1, BYTE_CYCLES, "frame start");
        send_byte(CMD_DUMP);
        if (o_dump_active !== 1'b1) begin
            i_dbg_port_checker.report_failure("frame ended before the second D arrived");
        end
        wait_dump(1'b0, FRAME_CYCLES, "frame end");
        repeat (FRAME_CYCLES) @(negedge clk_in);
        wait_dump(1'b0, FRAME_CYCLES, "frame end");
        i_dbg_port_checker.finish_test(1, 1);

        i_dbg_port_checker.start_test("resume_periodic");
        probe = $random(seed);
        send_byte(CMD_RESUME);
        repeat (RESUME_PERIODS * DUMP_PERIOD) @(negedge clk_in);
        wait_dump(1'b0, FRAME_CYCLES, "frame end");
        i_dbg_port_checker.finish_test(RESUME_PERIODS - 1, RESUME_PERIODS + 1);

        i_dbg_port_checker.report_counts();
        if (errors == 0 && i_dbg_port_top.i_uart_tx.i_dbg_port_properties.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/dbg_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/dbg_cmd_decode.sv
verilog/dbg_dump_seq.sv
verilog/dbg_port_top.sv
bench/tb_clock.sv
bench/dbg_port_checker.sv
bench/dbg_port_properties.sv
bench/dbg_port_tb.sv

// File: Bender.yml
package:
  name: dbg_port

sources:
  - verilog/dbg_pkg.sv
  - verilog/uart_rx.sv
  - verilog/uart_tx.sv
  - verilog/dbg_cmd_decode.sv
  - verilog/dbg_dump_seq.sv
  - verilog/dbg_port_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/dbg_port_checker.sv
      - bench/dbg_port_properties.sv
      - bench/dbg_port_tb.sv
